//--- sim/shr_video_testdata.txt
# M address byte : video memory record, hex
# E name V H rgb : expected colour at raster V,H (decimal), 24-bit rgb hex
M 19D00 43
M 19D01 23
M 19D02 83
M 19E62 00
M 19E63 0F
M 19E64 A5
M 19E65 00
M 19E6E 89
M 19E6F 07
M 19E70 23
M 19E71 01
M 19E7A DE
M 19E7B 0C
M 12000 12
M 12001 21
M 120A0 20
M 120A1 01
M 12140 1B
E border_pre 32 31 555555
E border_mid 32 700 555555
E pal3_c0 32 32 FF0000
E pal3_c2 32 34 00AA55
E pal3_c4 32 36 00AA55
E pal3_c6 32 38 FF0000
E fill_c0 33 32 00AA55
E fill_c2 33 34 00AA55
E fill_c4 33 36 00AA55
E fill_c6 33 38 FF0000
E border_lo 33 10 2222FF
E border_hi 33 920 2222FF
E m640_q2 34 32 112233
E m640_q3 34 33 CCDDEE
E m640_q0 34 34 00AA55
E m640_q1 34 35 778899
E border_end 34 680 66AAFF

//--- shr_video.f
+incdir+hdl
hdl/shr_video_pkg.sv
hdl/raster_timing.sv
hdl/line_header_fetch.sv
hdl/pixel_fetch.sv
hdl/video_bus_arbiter.sv
hdl/shr_pixel_render.sv
hdl/shr_video_top.sv
sim/tb_clock_gen.sv
sim/shr_video_props.sv
sim/shr_video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= shr_video_tb
FLIST ?= shr_video.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard hdl/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/shr_video_tb.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module shr_video_tb;

    localparam int H_TOTAL = 928;
    localparam int V_FIRST = 28;
    localparam int V_LAST = 201;
    localparam int H_STOP = 100;
    localparam int CLK_NS = 40;
    localparam int DRIVE_DLY = 2;
    localparam int MEM_SIZE = 1 << `SHR_ADDR_W;
    localparam int MAX_EXP = 64;
    // Four clock periods per raster column covers the random ce gaps
    localparam longint WATCHDOG_NS = longint'(V_LAST - V_FIRST + 1) * H_TOTAL * 4 * CLK_NS;

    logic clk_vid;
    logic reset;
    logic ce_pix;
    logic [9:0] h;
    logic [8:0] v;
    logic [3:0] border_color;
    logic [7:0] video_data;
    logic [`SHR_ADDR_W-1:0] video_addr;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic scanline_irq;
    logic vbl_irq;

    // Video memory image, fill pattern overlaid by the data file
    logic [7:0] mem [MEM_SIZE];
    logic [8*16-1:0] exp_name [MAX_EXP];
    logic [23:0] exp_rgb [MAX_EXP];
    bit exp_hit [MAX_EXP];
    int exp_at [int];
    int num_exp;
    integer seed;
    int scan_seen;
    int scan_want;
    int vbl_seen;
    int vbl_want;
    // Raster samples taken by the DUT, oldest first
    int pipe_key [$];

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) clk_gen_i (
        .clk_vid(clk_vid),
        .reset(reset)
    );

    shr_video_top dut_i (
        .clk_vid(clk_vid),
        .reset(reset),
        .ce_pix(ce_pix),
        .h(h),
        .v(v),
        .border_color(border_color),
        .video_data(video_data),
        .video_addr(video_addr),
        .r(r),
        .g(g),
        .b(b),
        .scanline_irq(scanline_irq),
        .vbl_irq(vbl_irq)
    );

    task automatic stop_run(input string why);
        $display("ERROR: %0s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [8*16-1:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Pattern mixes every address bit
    task automatic fill_memory();
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem[17'(i)] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
    endtask

    task automatic load_testdata();
        int fd;
        int n;
        logic [8*96-1:0] text;
        logic [8*8-1:0] kind;
        logic [8*16-1:0] name;
        logic [`SHR_ADDR_W-1:0] addr;
        logic [7:0] data;
        int tv;
        int th;
        logic [23:0] rgb;
        fd = $fopen("sim/shr_video_testdata.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the test data file");
        end
        num_exp = 0;
        while (!$feof(fd)) begin
            text = '0;
            kind = '0;
            n = $fgets(text, fd);
            n = $sscanf(text, "%s", kind);
            // M records patch memory, E records give an expected colour
            if (kind == "M") begin
                n = $sscanf(text, "%s %h %h", kind, addr, data);
                mem[addr] = data;
            end else if (kind == "E") begin
                n = $sscanf(text, "%s %s %d %d %h", kind, name, tv, th, rgb);
                exp_name[num_exp] = name;
                exp_rgb[num_exp] = rgb;
                exp_hit[num_exp] = 1'b0;
                exp_at[tv * 1024 + th] = num_exp;
                num_exp++;
            end
        end
        $fclose(fd);
    endtask

    // Border index written at line start, then changed halfway along
    function automatic logic [3:0] border_schedule(input int vv, input int hh);
        if (hh < 400) begin
            return 4'(vv + 5);
        end
        return 4'(vv + 11);
    endfunction

    task automatic check_sample(input int key);
        int idx;
        if (exp_at.exists(key)) begin
            idx = exp_at[key];
            check_value(exp_name[idx], {8'd0, exp_rgb[idx]}, {8'd0, r, g, b});
            exp_hit[idx] = 1'b1;
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog expired before the raster reached its last line");
    end

    initial begin
        int h_cur;
        int v_cur;
        int hdr_line;
        int missing;
        logic ce_was;
        logic [`SHR_ADDR_W-1:0] addr_last;
        bit done;
        seed = 32'h4260_8bb8;
        ce_pix = 1'b0;
        h = 10'd0;
        v = 9'(V_FIRST);
        border_color = 4'd0;
        video_data = 8'd0;
        h_cur = 0;
        v_cur = V_FIRST;
        addr_last = '0;
        done = 1'b0;
        scan_seen = 0;
        scan_want = 0;
        vbl_seen = 0;
        vbl_want = 0;
        fill_memory();
        load_testdata();
        while (!done) begin
            @(posedge clk_vid);
            ce_was = ce_pix;
            #DRIVE_DLY;
            if (scanline_irq) begin
                scan_seen++;
            end
            if (vbl_irq) begin
                vbl_seen++;
            end
            if (ce_was) begin
                // Memory answers with the address held before this edge
                video_data = mem[addr_last];
                pipe_key.push_back(v_cur * 1024 + h_cur);
                if (pipe_key.size() == `SHR_PIX_LATENCY) begin
                    check_sample(pipe_key.pop_front());
                end
                // Header window names the coming display line
                if (h_cur == int'(`SHR_HDR_START_H)) begin
                    hdr_line = v_cur - int'(`SHR_V_ACTIVE_START) + 1;
                    if (hdr_line >= 0 && hdr_line < 200 &&
                        mem[17'(`SHR_SCB_BASE + hdr_line)][6]) begin
                        scan_want++;
                    end
                end
                h_cur++;
                if (h_cur == H_TOTAL) begin
                    h_cur = 0;
                    v_cur++;
                    if (v_cur == int'(`SHR_VBL_LINE)) begin
                        vbl_want++;
                    end
                end
                done = (v_cur == V_LAST && h_cur == H_STOP);
            end
            addr_last = video_addr;
            ce_pix = !reset && (($random(seed) & 3) != 0);
            h = 10'(h_cur);
            v = 9'(v_cur);
            border_color = border_schedule(v_cur, h_cur);
        end
        check_value("scanline_irq", 32'(scan_want), 32'(scan_seen));
        check_value("vbl_irq", 32'(vbl_want), 32'(vbl_seen));
        missing = 0;
        for (int i = 0; i < num_exp; i++) begin
            if (!exp_hit[i]) begin
                missing++;
            end
        end
        if (missing == 0 && num_exp > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("ERROR: %0d of %0d expected samples were never checked", missing, num_exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "samples missing");
        end
    end

endmodule

//--- sim/shr_video_props.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module shr_video_props (
    input logic clk_vid,
    input logic reset,
    input logic ce_pix,
    input shr_video_pkg::bus_req_t hdr_req,
    input shr_video_pkg::bus_req_t pix_req,
    input logic scanline_irq,
    input logic vbl_irq,
    input logic [`SHR_ADDR_W-1:0] video_addr
);

    // Header and pixel fetch windows never overlap on the memory port
    one_owner: assert property (@(posedge clk_vid) disable iff (reset)
        !(hdr_req.valid && pix_req.valid))
        else $error("header and pixel requests pending together");

    vbl_pulse: assert property (@(posedge clk_vid) disable iff (reset)
        vbl_irq |=> !vbl_irq)
        else $error("vbl_irq high for more than one cycle");

    scan_pulse: assert property (@(posedge clk_vid) disable iff (reset)
        scanline_irq |=> !scanline_irq)
        else $error("scanline_irq high for more than one cycle");

    // Address register moves only on pixel clocks
    addr_on_ce: assert property (@(posedge clk_vid) disable iff (reset)
        !ce_pix |=> $stable(video_addr))
        else $error("video_addr changed without ce_pix");

endmodule

bind shr_video_top shr_video_props props_i (
    .clk_vid(clk_vid),
    .reset(reset),
    .ce_pix(ce_pix),
    .hdr_req(hdr_req),
    .pix_req(pix_req),
    .scanline_irq(scanline_irq),
    .vbl_irq(vbl_irq),
    .video_addr(video_addr)
);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_vid,
    output logic reset
);

    // Free-running video clock
    initial begin
        clk_vid = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_vid = ~clk_vid;
        end
    end

    // Reset drops just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_vid);
        #1 reset = 1'b0;
    end

endmodule

//--- hdl/shr_video_top.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module shr_video_top (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  logic [9:0] h,
    input  logic [8:0] v,
    input  logic [3:0] border_color,
    input  logic [7:0] video_data,
    output logic [`SHR_ADDR_W-1:0] video_addr,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output logic scanline_irq,
    output logic vbl_irq
);

    shr_video_pkg::raster_pos_t pos;
    logic [3:0] border_idx;
    shr_video_pkg::bus_req_t hdr_req;
    shr_video_pkg::bus_req_t pix_req;
    logic hdr_grant;
    logic pix_grant;
    shr_video_pkg::bus_rsp_t rsp;
    logic hdr_rsp_valid;
    logic pix_rsp_valid;
    shr_video_pkg::scb_t scb;
    shr_video_pkg::palette_entry_t [15:0] palette;
    logic [7:0] pix_byte;
    logic pix_strobe;

    raster_timing u_timing (
        .clk_vid(clk_vid), .reset(reset), .ce_pix(ce_pix),
        .h(h), .v(v), .border_color(border_color),
        .pos(pos), .border_idx(border_idx), .vbl_irq(vbl_irq)
    );

    line_header_fetch u_header (
        .clk_vid(clk_vid), .reset(reset), .ce_pix(ce_pix), .pos(pos),
        .req(hdr_req), .grant(hdr_grant), .rsp(rsp), .rsp_valid(hdr_rsp_valid),
        .scb(scb), .palette(palette), .scanline_irq(scanline_irq)
    );

    pixel_fetch u_pixel (
        .clk_vid(clk_vid), .reset(reset), .ce_pix(ce_pix), .pos(pos),
        .req(pix_req), .grant(pix_grant), .rsp(rsp), .rsp_valid(pix_rsp_valid),
        .pix_byte(pix_byte), .pix_strobe(pix_strobe)
    );

    video_bus_arbiter u_arbiter (
        .clk_vid(clk_vid), .reset(reset), .ce_pix(ce_pix),
        .hdr_req(hdr_req), .pix_req(pix_req),
        .hdr_grant(hdr_grant), .pix_grant(pix_grant),
        .video_addr(video_addr), .video_data(video_data), .rsp(rsp),
        .hdr_rsp_valid(hdr_rsp_valid), .pix_rsp_valid(pix_rsp_valid)
    );

    shr_pixel_render u_render (
        .clk_vid(clk_vid), .reset(reset), .ce_pix(ce_pix), .pos(pos),
        .border_idx(border_idx), .scb(scb), .palette(palette),
        .pix_byte(pix_byte), .pix_strobe(pix_strobe),
        .r(r), .g(g), .b(b)
    );

endmodule

//--- hdl/shr_pixel_render.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module shr_pixel_render (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  shr_video_pkg::raster_pos_t pos,
    input  logic [3:0] border_idx,
    input  shr_video_pkg::scb_t scb,
    input  shr_video_pkg::palette_entry_t [15:0] palette,
    input  logic [7:0] pix_byte,
    input  logic pix_strobe,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b
);

    // Fixed IIgs colour table for the border
    localparam shr_video_pkg::palette_entry_t BORDER_RGB [16] = '{
        12'h000, 12'hD03, 12'h009, 12'hD2D, 12'h072, 12'h555, 12'h22F, 12'h6AF,
        12'h850, 12'hF60, 12'hAAA, 12'hF98, 12'h1D0, 12'hFF0, 12'h4F9, 12'hFFF
    };

    logic [7:0] pend_byte;
    logic [7:0] cur_byte;
    logic [7:0] byte_now;
    logic [9:0] act_col;
    logic [3:0] nib;
    logic [3:0] idx_next;
    logic [3:0] last_idx;
    logic is_active;
    logic s2_border;
    logic [3:0] s2_idx;
    logic [3:0] s2_bidx;
    shr_video_pkg::palette_entry_t rgb_sel;

    assign is_active = (pos.phase == shr_video_pkg::PH_ACTIVE);
    assign act_col = pos.col - `SHR_FETCH_LEAD;
    // First column of a byte takes the freshly fetched one
    assign byte_now = (act_col[1:0] == 2'd0) ? pend_byte : cur_byte;
    // 320 mode, each nibble spans two columns
    assign nib = act_col[1] ? byte_now[3:0] : byte_now[7:4];

    always_comb begin
        if (scb.mode640) begin
            // Each 2-bit pixel picks its own palette quarter
            case (act_col[1:0])
                2'd0: idx_next = {2'b10, byte_now[7:6]};
                2'd1: idx_next = {2'b11, byte_now[5:4]};
                2'd2: idx_next = {2'b00, byte_now[3:2]};
                default: idx_next = {2'b01, byte_now[1:0]};
            endcase
        end else if (scb.fill_en && nib == 4'd0) begin
            idx_next = last_idx;
        end else begin
            idx_next = nib;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (ce_pix) begin
            if (pix_strobe) begin
                pend_byte <= pix_byte;
            end
            if (is_active && act_col[1:0] == 2'd0) begin
                cur_byte <= pend_byte;
            end
            s2_idx <= idx_next;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            last_idx <= 4'd0;
            s2_border <= 1'b1;
            s2_bidx <= 4'd0;
        end else if (ce_pix) begin
            s2_border <= !is_active;
            s2_bidx <= border_idx;
            // Fill colour restarts every line
            if (!is_active) begin
                last_idx <= 4'd0;
            end else if (!scb.mode640 && nib != 4'd0) begin
                last_idx <= nib;
            end
        end
    end

    assign rgb_sel = s2_border ? BORDER_RGB[s2_bidx] : palette[s2_idx];

    // Nibbles doubled up to 8 bits
    always_ff @(posedge clk_vid) begin
        if (reset) begin
            r <= 8'd0;
            g <= 8'd0;
            b <= 8'd0;
        end else if (ce_pix) begin
            r <= {rgb_sel.r, rgb_sel.r};
            g <= {rgb_sel.g, rgb_sel.g};
            b <= {rgb_sel.b, rgb_sel.b};
        end
    end

endmodule

//--- hdl/video_bus_arbiter.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module video_bus_arbiter (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  shr_video_pkg::bus_req_t hdr_req,
    input  shr_video_pkg::bus_req_t pix_req,
    output logic hdr_grant,
    output logic pix_grant,
    output logic [`SHR_ADDR_W-1:0] video_addr,
    input  logic [7:0] video_data,
    output shr_video_pkg::bus_rsp_t rsp,
    output logic hdr_rsp_valid,
    output logic pix_rsp_valid
);

    shr_video_pkg::bus_owner_e owner_next;
    // Owner of the address on the port, then of the byte coming back
    shr_video_pkg::bus_owner_e owner_addr;
    shr_video_pkg::bus_owner_e owner_data;

    // Header beats pixel
    assign hdr_grant = ce_pix && hdr_req.valid;
    assign pix_grant = ce_pix && pix_req.valid && !hdr_req.valid;

    always_comb begin
        if (hdr_grant) begin
            owner_next = shr_video_pkg::OWN_HEADER;
        end else if (pix_grant) begin
            owner_next = shr_video_pkg::OWN_PIXEL;
        end else begin
            owner_next = shr_video_pkg::OWN_NONE;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            video_addr <= '0;
            owner_addr <= shr_video_pkg::OWN_NONE;
            owner_data <= shr_video_pkg::OWN_NONE;
        end else if (ce_pix) begin
            if (hdr_grant) begin
                video_addr <= hdr_req.addr;
            end else if (pix_grant) begin
                video_addr <= pix_req.addr;
            end
            owner_addr <= owner_next;
            owner_data <= owner_addr;
        end
    end

    // Memory data lines up with owner_data
    assign rsp.data = video_data;
    assign rsp.valid = ce_pix && (owner_data != shr_video_pkg::OWN_NONE);
    assign hdr_rsp_valid = ce_pix && (owner_data == shr_video_pkg::OWN_HEADER);
    assign pix_rsp_valid = ce_pix && (owner_data == shr_video_pkg::OWN_PIXEL);

endmodule

//--- hdl/pixel_fetch.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module pixel_fetch (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  shr_video_pkg::raster_pos_t pos,
    output shr_video_pkg::bus_req_t req,
    input  logic grant,
    input  shr_video_pkg::bus_rsp_t rsp,
    input  logic rsp_valid,
    output logic [7:0] pix_byte,
    output logic pix_strobe
);

    logic [`SHR_ADDR_W-1:0] line_base;
    logic line_valid;
    logic fetch_slot;

    assign line_valid = (pos.line < 8'(`SHR_V_ACTIVE_END - `SHR_V_ACTIVE_START));
    // One byte every fourth column, 160 bytes per line
    assign fetch_slot = line_valid && (pos.col[1:0] == 2'd0) &&
                        (pos.col < {`SHR_BYTES_PER_LINE, 2'd0});

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            req <= '0;
            line_base <= `SHR_PIXEL_BASE;
            pix_strobe <= 1'b0;
        end else if (ce_pix) begin
            pix_strobe <= rsp_valid;
            // Base steps by one line per header window, restarting at line 0
            if (pos.first_line_cycle) begin
                if (pos.line == 8'd0) begin
                    line_base <= `SHR_PIXEL_BASE;
                end else if (line_valid) begin
                    line_base <= line_base + {9'd0, `SHR_BYTES_PER_LINE};
                end
            end
            if (grant) begin
                req.valid <= 1'b0;
            end
            if (fetch_slot) begin
                req.valid <= 1'b1;
                req.addr <= line_base + {9'd0, pos.col[9:2]};
            end
        end
    end

    // Returned byte is held until the next one
    always_ff @(posedge clk_vid) begin
        if (ce_pix && rsp_valid) begin
            pix_byte <= rsp.data;
        end
    end

endmodule

//--- hdl/line_header_fetch.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module line_header_fetch (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  shr_video_pkg::raster_pos_t pos,
    output shr_video_pkg::bus_req_t req,
    input  logic grant,
    input  shr_video_pkg::bus_rsp_t rsp,
    input  logic rsp_valid,
    output shr_video_pkg::scb_t scb,
    output shr_video_pkg::palette_entry_t [15:0] palette,
    output logic scanline_irq
);

    shr_video_pkg::hdr_state_e state;
    shr_video_pkg::scb_t scb_in;
    logic [7:0] line_q;
    logic [4:0] issue_cnt;
    logic [4:0] recv_cnt;

    assign scb_in = rsp.data;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            state <= shr_video_pkg::HDR_IDLE;
            req <= '0;
            scb <= '0;
            line_q <= 8'hFF;
            issue_cnt <= 5'd0;
            recv_cnt <= 5'd0;
            scanline_irq <= 1'b0;
        end else begin
            scanline_irq <= 1'b0;
            if (ce_pix) begin
                // Palette reads go out back to back, one per grant
                if (grant) begin
                    if (state == shr_video_pkg::HDR_PALETTE && issue_cnt != 5'd31) begin
                        req.addr <= req.addr + 1'b1;
                        issue_cnt <= issue_cnt + 1'b1;
                    end else begin
                        req.valid <= 1'b0;
                    end
                end
                case (state)
                    shr_video_pkg::HDR_IDLE: begin
                        if (pos.first_line_cycle) begin
                            line_q <= pos.line;
                            req.valid <= 1'b1;
                            req.addr <= `SHR_SCB_BASE + {9'd0, pos.line};
                            state <= shr_video_pkg::HDR_SCB;
                        end
                    end
                    shr_video_pkg::HDR_SCB: begin
                        if (rsp_valid) begin
                            scb <= scb_in;
                            // Only real display lines may interrupt
                            scanline_irq <= scb_in.irq_en &&
                                (line_q < 8'(`SHR_V_ACTIVE_END - `SHR_V_ACTIVE_START));
                            // Each palette is 32 bytes
                            req.valid <= 1'b1;
                            req.addr <= `SHR_PALETTE_BASE + {8'd0, scb_in.palette, 5'd0};
                            issue_cnt <= 5'd0;
                            recv_cnt <= 5'd0;
                            state <= shr_video_pkg::HDR_PALETTE;
                        end
                    end
                    shr_video_pkg::HDR_PALETTE: begin
                        if (rsp_valid) begin
                            recv_cnt <= recv_cnt + 1'b1;
                            if (recv_cnt == 5'd31) begin
                                state <= shr_video_pkg::HDR_IDLE;
                            end
                        end
                    end
                    default: state <= shr_video_pkg::HDR_IDLE;
                endcase
            end
        end
    end

    // Even byte holds green and blue, odd byte holds red in its low nibble
    always_ff @(posedge clk_vid) begin
        if (ce_pix && rsp_valid && state == shr_video_pkg::HDR_PALETTE) begin
            if (!recv_cnt[0]) begin
                palette[recv_cnt[4:1]].g <= rsp.data[7:4];
                palette[recv_cnt[4:1]].b <= rsp.data[3:0];
            end else begin
                palette[recv_cnt[4:1]].r <= rsp.data[3:0];
            end
        end
    end

endmodule

//--- hdl/raster_timing.sv
`timescale 1ns/1ps
`include "shr_video_defs.svh"

module raster_timing (
    input  logic clk_vid,
    input  logic reset,
    input  logic ce_pix,
    input  logic [9:0] h,
    input  logic [8:0] v,
    input  logic [3:0] border_color,
    output shr_video_pkg::raster_pos_t pos,
    output logic [3:0] border_idx,
    output logic vbl_irq
);

    shr_video_pkg::raster_pos_t pos_next;
    logic late_zone;
    logic [9:0] v_off;
    logic [9:0] line_raw;
    logic v_in_blank;
    logic v_in_blank_d;

    // From the header start onwards the line field names the coming line
    assign late_zone = (h >= `SHR_HDR_START_H);
    assign v_off = {1'b0, v} - {1'b0, `SHR_V_ACTIVE_START};
    assign line_raw = v_off + {9'd0, late_zone};
    assign v_in_blank = (v >= `SHR_VBL_LINE);

    always_comb begin
        pos_next.col = h - (`SHR_H_ACTIVE_START - `SHR_FETCH_LEAD);
        // Negative offsets wrap high, so one compare covers both ends
        if (line_raw < {1'b0, `SHR_V_ACTIVE_END - `SHR_V_ACTIVE_START}) begin
            pos_next.line = line_raw[7:0];
        end else begin
            pos_next.line = 8'hFF;
        end
        pos_next.first_line_cycle = (h == `SHR_HDR_START_H);
        if (v >= `SHR_V_ACTIVE_START && v < `SHR_V_ACTIVE_END &&
            h >= `SHR_H_ACTIVE_START && h < `SHR_H_ACTIVE_END) begin
            pos_next.phase = shr_video_pkg::PH_ACTIVE;
        end else if (late_zone || h < `SHR_H_ACTIVE_START) begin
            pos_next.phase = shr_video_pkg::PH_HEADER;
        end else begin
            pos_next.phase = shr_video_pkg::PH_BORDER;
        end
    end

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            pos <= '{phase: shr_video_pkg::PH_BORDER, col: '0, line: 8'hFF,
                     first_line_cycle: 1'b0};
            border_idx <= 4'd0;
            // Start as if already in blank so no pulse fires out of reset
            v_in_blank_d <= 1'b1;
            vbl_irq <= 1'b0;
        end else begin
            vbl_irq <= ce_pix && v_in_blank && !v_in_blank_d;
            if (ce_pix) begin
                pos <= pos_next;
                v_in_blank_d <= v_in_blank;
                // Border holds for the whole line
                if (h == 10'd0) begin
                    border_idx <= border_color;
                end
            end
        end
    end

endmodule

//--- hdl/shr_video_pkg.sv
`include "shr_video_defs.svh"

package shr_video_pkg;

    // Where the raster is within a line
    typedef enum logic [1:0] {
        PH_BORDER,
        PH_ACTIVE,
        PH_HEADER
    } line_phase_e;

    // Registered raster position
    // Column counts from the fetch lead, line is 8'hFF outside the 200 lines
    typedef struct packed {
        line_phase_e phase;
        logic [9:0] col;
        logic [7:0] line;
        logic first_line_cycle;
    } raster_pos_t;

    // Scan control byte as stored in memory
    typedef struct packed {
        logic mode640;
        logic irq_en;
        logic fill_en;
        logic spare;
        logic [3:0] palette;
    } scb_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } palette_entry_t;

    typedef struct packed {
        logic valid;
        logic [`SHR_ADDR_W-1:0] addr;
    } bus_req_t;

    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } bus_rsp_t;

    // Who owns the byte currently on the memory port
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_HEADER,
        OWN_PIXEL
    } bus_owner_e;

    typedef enum logic [1:0] {
        HDR_IDLE,
        HDR_SCB,
        HDR_PALETTE
    } hdr_state_e;

endpackage

//--- hdl/shr_video_defs.svh
`ifndef SHR_VIDEO_DEFS_SVH
`define SHR_VIDEO_DEFS_SVH

// Video memory address width
`define SHR_ADDR_W 17

// Active display rectangle in raster counts
`define SHR_H_ACTIVE_START 10'd32
`define SHR_H_ACTIVE_END 10'd672
`define SHR_V_ACTIVE_START 9'd32
`define SHR_V_ACTIVE_END 9'd232

// Header fetch for the coming line opens here, late in the current line
`define SHR_HDR_START_H 10'h38C

// First line of vertical blank
`define SHR_VBL_LINE 9'd199

// Video memory map
`define SHR_PIXEL_BASE 17'h12000
`define SHR_BYTES_PER_LINE 8'd160
`define SHR_SCB_BASE 17'h19D00
`define SHR_PALETTE_BASE 17'h19E00

// Pixel bytes are requested this many columns before they are shown
`define SHR_FETCH_LEAD 10'd6

// Pixel clocks from an H sample to its RGB
`define SHR_PIX_LATENCY 3

`endif
